// File: common/rom_pkg.sv
/*
 * Firmware ROM definitions
 * Byte address and data widths, bank count, image size codes, and the
 * rules that turn loader writes into a size code and mask read addresses.
 */
package rom_pkg;

	localparam int ROM_AW    = 15;
	localparam int ROM_DW    = 8;
	localparam int ROM_DEPTH = 1 << ROM_AW;
	localparam int ROM_BANKS = 2;

	typedef logic [ROM_AW-1:0] rom_addr_t;
	typedef logic [ROM_DW-1:0] rom_data_t;

	// mask for address bits 14:13
	typedef logic [1:0] rom_size_t;

	localparam rom_size_t SIZE_8K  = 2'b00;
	localparam rom_size_t SIZE_16K = 2'b01;
	localparam rom_size_t SIZE_32K = 2'b11;

	// only bytes other than 00/FF count as image content
	function automatic logic sizing_byte(rom_data_t d);
		return (d != '0) && (d != '1);
	endfunction

	function automatic rom_size_t size_code(rom_addr_t a);
		return a[14] ? SIZE_32K : (a[13] ? SIZE_16K : SIZE_8K);
	endfunction

	function automatic rom_addr_t mask_addr(rom_addr_t a, rom_size_t s);
		return {a[14:13] & s, a[12:0]};
	endfunction

endpackage

// File: common/drive_pkg.sv
/*
 * Drive unit definitions
 * Bank select, command and result widths, ROM slot counter and the
 * command engine states shared by the drives and the slot arbiter.
 */
package drive_pkg;

	// upper bound on DRIVES, limited by the slot count per phase
	localparam int MAX_DRIVES = 4;

	// bank select per drive
	typedef logic drv_mode_t;

	// byte count, 0 stands for 256
	typedef logic [7:0] cmd_len_t;

	typedef logic [15:0] sum_t;

	typedef logic [2:0] slot_t;

	// counter parks here between fall strobes
	localparam slot_t SLOT_IDLE = 3'd7;

	// slots from address issue to byte delivery
	localparam int SLOT_LAG = 3;

	typedef enum logic [1:0] {
		IDLE,
		FETCH,
		DONE
	} drv_state_t;

endpackage

// File: hw/phase_gen.sv
/*
 * Bus phase generator
 * Divides the clock enable by 16 into a rise strobe and a fall strobe
 * half a phase apart. Pause goes through two stages and is only taken
 * on divider boundaries, so a phase is never cut short.
 */
`timescale 1ns/100ps

module phase_gen (
	input  logic clk,
	input  logic arst_n_i,
	input  logic ce_i,
	input  logic pause_i,
	output logic ph_rise_o,
	output logic ph_fall_o
);

	logic [3:0] div;
	logic       ena_meta;
	logic       ena;

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			div       <= '0;
			ena_meta  <= 1'b0;
			ena       <= 1'b0;
			ph_rise_o <= 1'b0;
			ph_fall_o <= 1'b0;
		end else begin
			ena_meta <= ~pause_i;
			// hold the enable steady around the strobe points
			if (div[2:0] != 3'd0) begin
				ena <= ena_meta;
			end

			ph_rise_o <= 1'b0;
			ph_fall_o <= 1'b0;
			if (ce_i) begin
				div       <= div + 4'd1;
				ph_rise_o <= ena && (div == 4'd0);
				ph_fall_o <= ena && (div == 4'd8);
			end
		end
	end

endmodule

// File: hw/rom_store.sv
/*
 * Shared firmware ROM store
 * Two 32K banks written by the loader, one registered read port with one
 * cycle of latency, and a size code per bank worked out from where the
 * image content was written.
 */
`timescale 1ns/100ps

module rom_store (
	input  logic                                          clk,
	input  logic                                          arst_n_i,
	input  logic                                          rom_wr_i,
	input  logic                                          rom_sel_i,
	input  rom_pkg::rom_addr_t                            rom_addr_i,
	input  rom_pkg::rom_data_t                            rom_data_i,
	input  drive_pkg::drv_mode_t                          rd_bank_i,
	input  rom_pkg::rom_addr_t                            rd_addr_i,
	output rom_pkg::rom_data_t                            rd_data_o,
	output rom_pkg::rom_size_t [rom_pkg::ROM_BANKS-1:0]   rom_size_o
);

	import rom_pkg::*;
	import drive_pkg::*;

	rom_data_t bank_rd [ROM_BANKS];
	drv_mode_t bank_q;

	// ------------------------------------------------------------------------
	// bank arrays
	// ------------------------------------------------------------------------

	for (genvar b = 0; b < ROM_BANKS; b++) begin : g_bank
		rom_data_t mem [ROM_DEPTH];

		always_ff @(posedge clk) begin
			if (rom_wr_i && (rom_sel_i == b)) begin
				mem[rom_addr_i] <= rom_data_i;
			end
		end

		// every bank reads each cycle, the bank select picks one after
		always_ff @(posedge clk) begin
			bank_rd[b] <= mem[rd_addr_i];
		end
	end

	always_ff @(posedge clk) begin
		bank_q <= rd_bank_i;
	end

	assign rd_data_o = bank_rd[bank_q];

	// ------------------------------------------------------------------------
	// image size detection
	// ------------------------------------------------------------------------

	// highest region holding real content sets the size,
	// a later write lower down shrinks it again
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			rom_size_o <= {ROM_BANKS{SIZE_32K}};
		end else if (rom_wr_i && sizing_byte(rom_data_i)) begin
			rom_size_o[rom_sel_i] <= size_code(rom_addr_i);
		end
	end

endmodule

// File: hw/rom_slot_arb.sv
/*
 * ROM slot arbiter
 * Gives each drive one read slot of the shared ROM port per bus phase.
 * Addresses are masked to the image size of the selected bank, and each
 * byte comes back to its drive three slots later with a valid pulse.
 */
`timescale 1ns/100ps

module rom_slot_arb #(
	parameter int DRIVES = 2
) (
	input  logic                                          clk,
	input  logic                                          arst_n_i,
	input  logic                                          ph_fall_i,
	input  drive_pkg::drv_mode_t [DRIVES-1:0]             drv_mode_i,
	input  rom_pkg::rom_addr_t [DRIVES-1:0]               drv_addr_i,
	input  rom_pkg::rom_size_t [rom_pkg::ROM_BANKS-1:0]   rom_size_i,
	input  rom_pkg::rom_data_t                            rd_data_i,
	output drive_pkg::drv_mode_t                          rd_bank_o,
	output rom_pkg::rom_addr_t                            rd_addr_o,
	output rom_pkg::rom_data_t [DRIVES-1:0]               drv_data_o,
	output logic [DRIVES-1:0]                             drv_valid_o
);

	import rom_pkg::*;
	import drive_pkg::*;

	slot_t slot;

	// restart on every fall strobe, then run once up to the park value
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			slot <= SLOT_IDLE;
		end else if (ph_fall_i) begin
			slot <= '0;
		end else if (slot != SLOT_IDLE) begin
			slot <= slot + slot_t'(1);
		end
	end

	// ------------------------------------------------------------------------
	// address issue, slot i belongs to drive i
	// ------------------------------------------------------------------------

	always_ff @(posedge clk) begin
		for (int i = 0; i < DRIVES; i++) begin
			if (slot == slot_t'(i)) begin
				rd_addr_o <= mask_addr(drv_addr_i[i], rom_size_i[drv_mode_i[i]]);
				rd_bank_o <= drv_mode_i[i];
			end
		end
	end

	// ------------------------------------------------------------------------
	// data return
	// ------------------------------------------------------------------------

	// one cycle for the address register, one for the store read,
	// so the byte is captured two slots on and shows up at slot i+3
	always_ff @(posedge clk) begin
		for (int i = 0; i < DRIVES; i++) begin
			if (slot == slot_t'(i + SLOT_LAG - 1)) begin
				drv_data_o[i] <= rd_data_i;
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			drv_valid_o <= '0;
		end else begin
			for (int i = 0; i < DRIVES; i++) begin
				drv_valid_o[i] <= (slot == slot_t'(i + SLOT_LAG - 1));
			end
		end
	end

endmodule

// File: drive/drive_unit.sv
/*
 * Drive command engine
 * Takes a start address and byte count over a four-phase req/ack
 * handshake, reads that many bytes through its ROM slot and returns
 * their 16-bit sum. LED on and bus line pulled low while busy.
 */
`timescale 1ns/100ps

module drive_unit (
	input  logic                   clk,
	input  logic                   arst_n_i,
	input  drive_pkg::drv_mode_t   drv_mode_i,
	input  logic                   cmd_req_i,
	input  rom_pkg::rom_addr_t     cmd_addr_i,
	input  drive_pkg::cmd_len_t    cmd_len_i,
	input  rom_pkg::rom_data_t     rom_data_i,
	input  logic                   rom_valid_i,
	output logic                   cmd_ack_o,
	output drive_pkg::sum_t        cmd_sum_o,
	output rom_pkg::rom_addr_t     rom_addr_o,
	output logic                   led_o,
	output logic                   bus_o
);

	import drive_pkg::*;

	drv_state_t state;
	cmd_len_t   left;
	drv_mode_t  mode_q;
	logic       skip;
	logic       mode_chg;
	logic       take;
	logic       start;

	assign start    = (state == IDLE) && cmd_req_i;
	assign mode_chg = (drv_mode_i != mode_q);

	// the byte in flight may belong to an older address or bank
	assign take = (state == FETCH) && rom_valid_i && !skip && !mode_chg;

	// ------------------------------------------------------------------------
	// control FSM
	// ------------------------------------------------------------------------

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state  <= IDLE;
			mode_q <= '0;
			skip   <= 1'b0;
		end else begin
			mode_q <= drv_mode_i;
			case (state)
				IDLE: begin
					if (cmd_req_i) begin
						state <= FETCH;
						// address may have missed this phase's slot
						skip  <= 1'b1;
					end
				end
				FETCH: begin
					if (mode_chg) begin
						skip <= 1'b1;
					end else if (rom_valid_i) begin
						skip <= 1'b0;
					end
					// count of 0 wraps through 255 and runs 256 bytes
					if (take && (left == cmd_len_t'(1))) begin
						state <= DONE;
					end
				end
				DONE: begin
					if (!cmd_req_i) begin
						state <= IDLE;
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// ------------------------------------------------------------------------
	// address, count and sum
	// ------------------------------------------------------------------------

	// address only moves right after a valid pulse,
	// so it is steady by the next slot
	always_ff @(posedge clk) begin
		if (start) begin
			rom_addr_o <= cmd_addr_i;
			left       <= cmd_len_i;
			cmd_sum_o  <= '0;
		end else if (take) begin
			rom_addr_o <= rom_addr_o + 1'b1;
			left       <= left - 1'b1;
			cmd_sum_o  <= cmd_sum_o + sum_t'(rom_data_i);
		end
	end

	assign cmd_ack_o = (state == DONE);
	assign led_o     = (state != IDLE);
	assign bus_o     = (state == IDLE);

endmodule

// File: hw/drive_multi.sv
/*
 * Multi-drive controller top level
 * Phase generator, shared two-bank ROM store, slot arbiter and a row of
 * drive units. Per-drive resets are synchronized here, and the drives'
 * open-collector bus lines are combined as a wired AND.
 */
`timescale 1ns/100ps

module drive_multi #(
	parameter int DRIVES = 2
) (
	input  logic                                clk,
	input  logic                                arst_n_i,
	input  logic [DRIVES-1:0]                   drv_rst_i,
	input  logic                                ce_i,
	input  logic                                pause_i,
	input  drive_pkg::drv_mode_t [DRIVES-1:0]   drv_mode_i,
	input  logic [DRIVES-1:0]                   cmd_req_i,
	input  rom_pkg::rom_addr_t [DRIVES-1:0]     cmd_addr_i,
	input  drive_pkg::cmd_len_t [DRIVES-1:0]    cmd_len_i,
	output logic [DRIVES-1:0]                   cmd_ack_o,
	output drive_pkg::sum_t [DRIVES-1:0]        cmd_sum_o,
	input  logic                                rom_wr_i,
	input  logic                                rom_sel_i,
	input  rom_pkg::rom_addr_t                  rom_addr_i,
	input  rom_pkg::rom_data_t                  rom_data_i,
	output logic [DRIVES-1:0]                   led_o,
	output logic                                bus_o
);

	import rom_pkg::*;
	import drive_pkg::*;

	if ((DRIVES < 1) || (DRIVES > MAX_DRIVES)) begin : g_drives_range
		$error("drive_multi: DRIVES must be 1 to %0d", MAX_DRIVES);
	end

	logic                         ph_fall;
	rom_size_t [ROM_BANKS-1:0]    rom_size;
	drv_mode_t                    rd_bank;
	rom_addr_t                    rd_addr;
	rom_data_t                    rd_data;
	rom_addr_t [DRIVES-1:0]       drv_addr;
	rom_data_t [DRIVES-1:0]       drv_data;
	logic [DRIVES-1:0]            drv_valid;
	logic [DRIVES-1:0]            drv_led;
	logic [DRIVES-1:0]            drv_bus;
	logic [DRIVES-1:0]            rst_meta_n;
	logic [DRIVES-1:0]            drv_arst_n;

	// two-stage drive reset, also forced by the main reset
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			rst_meta_n <= '0;
			drv_arst_n <= '0;
		end else begin
			rst_meta_n <= ~drv_rst_i;
			drv_arst_n <= rst_meta_n;
		end
	end

	phase_gen i_phase_gen (
		.clk       (clk),
		.arst_n_i  (arst_n_i),
		.ce_i      (ce_i),
		.pause_i   (pause_i),
		.ph_rise_o (),
		.ph_fall_o (ph_fall)
	);

	rom_store i_rom_store (
		.clk        (clk),
		.arst_n_i   (arst_n_i),
		.rom_wr_i   (rom_wr_i),
		.rom_sel_i  (rom_sel_i),
		.rom_addr_i (rom_addr_i),
		.rom_data_i (rom_data_i),
		.rd_bank_i  (rd_bank),
		.rd_addr_i  (rd_addr),
		.rd_data_o  (rd_data),
		.rom_size_o (rom_size)
	);

	rom_slot_arb #(
		.DRIVES (DRIVES)
	) i_rom_slot_arb (
		.clk         (clk),
		.arst_n_i    (arst_n_i),
		.ph_fall_i   (ph_fall),
		.drv_mode_i  (drv_mode_i),
		.drv_addr_i  (drv_addr),
		.rom_size_i  (rom_size),
		.rd_data_i   (rd_data),
		.rd_bank_o   (rd_bank),
		.rd_addr_o   (rd_addr),
		.drv_data_o  (drv_data),
		.drv_valid_o (drv_valid)
	);

	for (genvar i = 0; i < DRIVES; i++) begin : g_drive
		drive_unit i_drive_unit (
			.clk         (clk),
			.arst_n_i    (drv_arst_n[i]),
			.drv_mode_i  (drv_mode_i[i]),
			.cmd_req_i   (cmd_req_i[i]),
			.cmd_addr_i  (cmd_addr_i[i]),
			.cmd_len_i   (cmd_len_i[i]),
			.rom_data_i  (drv_data[i]),
			.rom_valid_i (drv_valid[i]),
			.cmd_ack_o   (cmd_ack_o[i]),
			.cmd_sum_o   (cmd_sum_o[i]),
			.rom_addr_o  (drv_addr[i]),
			.led_o       (drv_led[i]),
			.bus_o       (drv_bus[i])
		);
	end

	// a drive held in reset lets its line float high
	assign bus_o = &(drv_bus | ~drv_arst_n);
	assign led_o = drv_led & drv_arst_n;

endmodule

// File: testbench/drive_multi_chk.sv
/*
 * Drive handshake and bus checks
 * Bound into every drive unit. Watches the req/ack sequence and the
 * relation between a pending request, the LED and the bus line.
 */
`timescale 1ns/100ps

module drive_multi_chk (
	input logic clk,
	input logic arst_n_i,
	input logic cmd_req_i,
	input logic cmd_ack_i,
	input logic led_i,
	input logic bus_i
);

	// ack only answers a pending request
	ack_needs_req: assert property (@(posedge clk) disable iff (!arst_n_i)
		$rose(cmd_ack_i) |-> cmd_req_i)
		else $error("drive raised ack without a request");

	ack_holds: assert property (@(posedge clk) disable iff (!arst_n_i)
		(cmd_ack_i && cmd_req_i) |=> cmd_ack_i)
		else $error("drive dropped ack while the request was still high");

	// a pending request keeps the drive busy, LED on and line pulled
	bus_when_busy: assert property (@(posedge clk) disable iff (!arst_n_i)
		cmd_req_i |=> (led_i && !bus_i))
		else $error("drive with a pending request is not busy on the bus");

endmodule

bind drive_unit drive_multi_chk i_drive_multi_chk (
	.clk       (clk),
	.arst_n_i  (arst_n_i),
	.cmd_req_i (cmd_req_i),
	.cmd_ack_i (cmd_ack_o),
	.led_i     (led_o),
	.bus_i     (bus_o)
);

// File: testbench/tb_drive_multi.sv
/*
 * Testbench for the multi-drive controller
 * Loads random ROM images, runs random commands on one drive or on all
 * of them, with pause and a drive held in reset, and checks every sum
 * against a byte model of both ROM banks.
 */
`timescale 1ns/100ps

module tb_drive_multi;

	import rom_pkg::*;
	import drive_pkg::*;

	localparam int DRIVES = 3;

	logic                   clk;
	logic                   arst_n;
	logic [DRIVES-1:0]      drv_rst;
	logic                   ce;
	logic                   pause;
	drv_mode_t [DRIVES-1:0] drv_mode;
	logic [DRIVES-1:0]      cmd_req;
	rom_addr_t [DRIVES-1:0] cmd_addr;
	cmd_len_t [DRIVES-1:0]  cmd_len;
	logic [DRIVES-1:0]      cmd_ack;
	sum_t [DRIVES-1:0]      cmd_sum;
	logic                   rom_wr;
	logic                   rom_sel;
	rom_addr_t              rom_addr;
	rom_data_t              rom_data;
	logic [DRIVES-1:0]      led;
	logic                   bus;

	// ROM model and next command per drive
	rom_data_t model_mem [2][ROM_DEPTH];
	logic [1:0] model_size [2];
	rom_addr_t  next_addr [DRIVES];
	cmd_len_t   next_len [DRIVES];
	drv_mode_t  next_mode [DRIVES];
	logic [2:0] ce_cnt;
	int errors;
	int hangs;
	int n;
	int d;

	drive_multi #(
		.DRIVES (DRIVES)
	) i_drive_multi (
		.clk        (clk),
		.arst_n_i   (arst_n),
		.drv_rst_i  (drv_rst),
		.ce_i       (ce),
		.pause_i    (pause),
		.drv_mode_i (drv_mode),
		.cmd_req_i  (cmd_req),
		.cmd_addr_i (cmd_addr),
		.cmd_len_i  (cmd_len),
		.cmd_ack_o  (cmd_ack),
		.cmd_sum_o  (cmd_sum),
		.rom_wr_i   (rom_wr),
		.rom_sel_i  (rom_sel),
		.rom_addr_i (rom_addr),
		.rom_data_i (rom_data),
		.led_o      (led),
		.bus_o      (bus)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// one ce every 8 clocks
	always @(posedge clk) begin
		ce_cnt <= ce_cnt + 3'd1;
		ce     <= (ce_cnt == 3'd7);
	end

	// ------------------------------------------------------------------------
	// model and checks
	// ------------------------------------------------------------------------

	task automatic compare(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			errors++;
			$display("ERR %s expected %0h actual %0h", name, expected, actual);
		end
	endtask

	// sum over wrapping addresses, bits 14:13 masked by the bank size
	function automatic sum_t expected_sum(drv_mode_t bank, rom_addr_t start, cmd_len_t len);
		sum_t      acc;
		rom_addr_t a;
		int        cnt;
		int        k;
		acc = '0;
		cnt = (len == 0) ? 256 : int'(len);
		for (k = 0; k < cnt; k++) begin
			a   = start + rom_addr_t'(k);
			acc = acc + {8'h00, model_mem[bank][{a[14:13] & model_size[bank], a[12:0]}]};
		end
		return acc;
	endfunction

	task automatic load_range(input logic sel, input int first, input int last);
		rom_data_t data;
		int        a;
		for (a = first; a <= last; a++) begin
			data = rom_data_t'($urandom);
			// last byte of the image must be real content
			if ((a == last) && ((data == 8'h00) || (data == 8'hff))) begin
				data = 8'h5a;
			end
			@(posedge clk);
			rom_wr   <= 1'b1;
			rom_sel  <= sel;
			rom_addr <= rom_addr_t'(a);
			rom_data <= data;
			model_mem[sel][a] = data;
			if ((data != 8'h00) && (data != 8'hff)) begin
				model_size[sel] = a[14] ? 2'b11 : (a[13] ? 2'b01 : 2'b00);
			end
		end
		@(posedge clk);
		rom_wr <= 1'b0;
		@(negedge clk);
		compare($sformatf("size_bank%0d", sel), model_size[sel], i_drive_multi.rom_size[sel]);
	endtask

	task automatic pick_cmd(input int dn, input drv_mode_t mode, input int base, input int span);
		next_mode[dn] = mode;
		next_addr[dn] = rom_addr_t'(base + ($urandom % span));
		next_len[dn]  = cmd_len_t'(1 + ($urandom % 24));
	endtask

	// the held drive must leave the bus and its LED alone
	task automatic watch_held(input int cycles);
		int k;
		for (k = 0; k < cycles; k++) begin
			@(negedge clk);
			compare("held_bus", 1, bus);
			compare("held_led", 0, led & drv_rst);
		end
	endtask

	// ------------------------------------------------------------------------
	// command batch on the drives in act
	// ------------------------------------------------------------------------

	task automatic run_batch(input logic [DRIVES-1:0] act, input logic toggle_pause);
		sum_t              exp_sum [DRIVES];
		logic [DRIVES-1:0] pending;
		logic [DRIVES-1:0] acked;
		logic [DRIVES-1:0] busy;
		int                limit;
		int                cycles;
		int                nb;
		int                i;
		if (hangs == 0) begin
			@(posedge clk);
			limit = 3000;
			for (i = 0; i < DRIVES; i++) begin
				if (act[i]) begin
					exp_sum[i] = expected_sum(next_mode[i], next_addr[i], next_len[i]);
					nb = (next_len[i] == 0) ? 256 : int'(next_len[i]);
					// one byte per 128-clock phase, pause may halve the rate
					if ((nb + 3) * 128 * 3 > limit) begin
						limit = (nb + 3) * 128 * 3;
					end
					drv_mode[i] <= next_mode[i];
				end
			end
			@(posedge clk);
			for (i = 0; i < DRIVES; i++) begin
				if (act[i]) begin
					cmd_addr[i] <= next_addr[i];
					cmd_len[i]  <= next_len[i];
					cmd_req[i]  <= 1'b1;
				end
			end
			pending  = act;
			acked    = '0;
			cycles   = 0;
			while (((pending | (cmd_ack & act)) != 0) && (cycles < limit)) begin
				@(posedge clk);
				cmd_req <= cmd_req & ~acked;
				if (toggle_pause && ((cycles % 400) == 200)) begin
					pause <= ~pause;
				end
				@(negedge clk);
				cycles++;
				busy = pending | (cmd_ack & act);
				if (busy != 0) begin
					compare("bus_busy", 0, bus);
				end
				for (i = 0; i < DRIVES; i++) begin
					if (busy[i]) begin
						compare($sformatf("led_d%0d", i), 1, led[i]);
					end
					if (drv_rst[i]) begin
						compare($sformatf("held_led_d%0d", i), 0, led[i]);
					end
					if (pending[i] && cmd_ack[i]) begin
						compare($sformatf("sum_d%0d", i), exp_sum[i], cmd_sum[i]);
						pending[i] = 1'b0;
						acked[i]   = 1'b1;
					end
				end
			end
			if ((pending | (cmd_ack & act)) != 0) begin
				$display("hang: drives %b did not finish the handshake in %0d cycles", act, limit);
				hangs++;
			end else begin
				compare("bus_idle", 1, bus);
			end
			@(posedge clk);
			pause <= 1'b0;
		end
	endtask

	// ------------------------------------------------------------------------
	// test sequence
	// ------------------------------------------------------------------------

	initial begin
		void'($urandom(32'h9544_b811));
		errors        = 0;
		hangs         = 0;
		ce_cnt        = '0;
		model_size[0] = 2'b11;
		model_size[1] = 2'b11;
		arst_n        = 1'b0;
		drv_rst       = '0;
		ce            = 1'b0;
		pause         = 1'b0;
		drv_mode      = '0;
		cmd_req       = '0;
		cmd_addr      = '0;
		cmd_len       = '0;
		rom_wr        = 1'b0;
		rom_sel       = 1'b0;
		rom_addr      = '0;
		rom_data      = '0;
		repeat (5) @(posedge clk);
		arst_n <= 1'b1;
		repeat (4) @(posedge clk);
		@(negedge clk);
		compare("reset_ack", 0, cmd_ack);
		compare("reset_led", 0, led);
		compare("reset_bus", 1, bus);
		compare("reset_valid", 0, i_drive_multi.drv_valid);

		// full random images, single-drive commands
		load_range(1'b0, 0, ROM_DEPTH - 1);
		load_range(1'b1, 0, ROM_DEPTH - 1);
		for (n = 0; n < 10; n++) begin
			d = $urandom % DRIVES;
			pick_cmd(d, drv_mode_t'($urandom), 0, ROM_DEPTH);
			run_batch(DRIVES'(1 << d), 1'b0);
		end
		// wrap past the top, then a 256-byte count
		pick_cmd(2, 1'b1, 'h7ff0, 1);
		next_len[2] = 8'd40;
		run_batch(3'b100, 1'b0);
		pick_cmd(0, 1'b0, 0, ROM_DEPTH);
		next_len[0] = 8'd0;
		run_batch(3'b001, 1'b0);

		// shrink bank 1 to 8K, then grow it to 16K
		load_range(1'b1, 0, 'h1fff);
		for (n = 0; n < 4; n++) begin
			pick_cmd(n % DRIVES, 1'b1, 'h2000, 'h6000);
			run_batch(DRIVES'(1 << (n % DRIVES)), 1'b0);
		end
		load_range(1'b1, 'h2000, 'h3fff);
		for (n = 0; n < 4; n++) begin
			pick_cmd(n % DRIVES, 1'b1, 'h4000, 'h4000);
			run_batch(DRIVES'(1 << (n % DRIVES)), 1'b0);
		end

		// all drives at once, mixed banks
		for (n = 0; n < 2; n++) begin
			for (d = 0; d < DRIVES; d++) begin
				pick_cmd(d, drv_mode_t'((d + n) % 2), 0, ROM_DEPTH);
			end
			run_batch('1, 1'b0);
		end

		// pause toggling, then drive 1 held in reset with its req up
		for (d = 0; d < DRIVES; d++) begin
			pick_cmd(d, drv_mode_t'(d % 2), 0, ROM_DEPTH);
		end
		run_batch('1, 1'b1);
		@(posedge clk);
		drv_rst <= 3'b010;
		repeat (4) @(posedge clk);
		cmd_req[1] <= 1'b1;
		watch_held(300);
		pick_cmd(0, 1'b1, 0, ROM_DEPTH);
		pick_cmd(2, 1'b0, 0, ROM_DEPTH);
		run_batch(3'b101, 1'b1);
		@(posedge clk);
		cmd_req[1] <= 1'b0;
		drv_rst    <= '0;
		repeat (4) @(posedge clk);
		pick_cmd(1, 1'b1, 0, ROM_DEPTH);
		run_batch(3'b010, 1'b0);

		$display("run complete: %0d errors, %0d hangs", errors, hangs);
		if ((errors == 0) && (hangs == 0)) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

// File: drive_multi.f
common/rom_pkg.sv
common/drive_pkg.sv
hw/phase_gen.sv
hw/rom_store.sv
hw/rom_slot_arb.sv
drive/drive_unit.sv
hw/drive_multi.sv
testbench/drive_multi_chk.sv
testbench/tb_drive_multi.sv
